// File: Bender.yml
package:
  name: decode_stage

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/riscv_isa_pkg.sv
      - hdl/decode_pkg.sv
      - hdl/instr_field_decoder.sv
      - hdl/jump_resolver.sv
      - hdl/return_address_stack.sv
      - hdl/decode_stage.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - tests/tb_clk_gen.sv
      - tests/decode_stage_chk.sv
      - tests/tb_decode_stage.sv

// File: hdl/decode_pkg.sv
`default_nettype none

package decode_pkg;

    // operation carried to the execution units
    typedef enum logic [4:0] {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        JAL,
        JALR,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU
    } instr_type_t;

    typedef enum logic [1:0] {
        UNIT_ALU,
        UNIT_BRANCH
    } unit_t;

    // decode-time exceptions, misaligned wins over illegal
    typedef enum logic [1:0] {
        XCPT_NONE,
        XCPT_ADDR_MISALIGNED,
        XCPT_ILLEGAL_INSTR
    } xcpt_cause_t;

endpackage

`default_nettype wire

// File: hdl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_defs.svh"

module decode_stage (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     valid_i,
    input  logic                     stall_i,
    input  logic [`XLEN-1:0]         pc_i,
    input  logic [`ILEN-1:0]         instr_i,
    output logic                     valid_o,
    output decode_pkg::instr_type_t  instr_type_o,
    output decode_pkg::unit_t        unit_o,
    output riscv_isa_pkg::reg_addr_t rs1_o,
    output riscv_isa_pkg::reg_addr_t rs2_o,
    output riscv_isa_pkg::reg_addr_t rd_o,
    output logic [`XLEN-1:0]         imm_o,
    output logic                     regfile_we_o,
    output logic                     use_imm_o,
    output logic                     use_pc_o,
    output logic                     change_pc_o,
    output logic                     jump_valid_o,
    output logic [`XLEN-1:0]         jump_addr_o,
    output logic                     xcpt_valid_o,
    output decode_pkg::xcpt_cause_t  xcpt_cause_o,
    output logic [`XLEN-1:0]         xcpt_origin_o
);

    logic             is_jal;
    logic             is_jalr;
    logic             illegal;
    logic             link_push;
    logic             link_pop;
    logic             ras_push;
    logic             ras_pop;
    logic [`XLEN-1:0] ras_push_addr;
    logic [`XLEN-1:0] ras_top;

    assign valid_o = valid_i;

    instr_field_decoder i_field_decoder (
        .valid_i      (valid_i),
        .instr_i      (instr_i),
        .instr_type_o (instr_type_o),
        .unit_o       (unit_o),
        .rs1_o        (rs1_o),
        .rs2_o        (rs2_o),
        .rd_o         (rd_o),
        .imm_o        (imm_o),
        .regfile_we_o (regfile_we_o),
        .use_imm_o    (use_imm_o),
        .use_pc_o     (use_pc_o),
        .change_pc_o  (change_pc_o),
        .is_jal_o     (is_jal),
        .is_jalr_o    (is_jalr),
        .illegal_o    (illegal),
        .link_push_o  (link_push),
        .link_pop_o   (link_pop)
    );

    jump_resolver i_jump_resolver (
        .valid_i         (valid_i),
        .stall_i         (stall_i),
        .pc_i            (pc_i),
        .imm_i           (imm_o),
        .is_jal_i        (is_jal),
        .is_jalr_i       (is_jalr),
        .illegal_i       (illegal),
        .link_push_i     (link_push),
        .link_pop_i      (link_pop),
        .ras_top_i       (ras_top),
        .ras_push_o      (ras_push),
        .ras_pop_o       (ras_pop),
        .ras_push_addr_o (ras_push_addr),
        .jump_valid_o    (jump_valid_o),
        .jump_addr_o     (jump_addr_o),
        .xcpt_valid_o    (xcpt_valid_o),
        .xcpt_cause_o    (xcpt_cause_o),
        .xcpt_origin_o   (xcpt_origin_o)
    );

    return_address_stack i_ras (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (ras_push_addr),
        .top_o       (ras_top)
    );

endmodule

`default_nettype wire

// File: hdl/instr_field_decoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_defs.svh"

module instr_field_decoder (
    input  logic                     valid_i,
    input  logic [`ILEN-1:0]         instr_i,
    output decode_pkg::instr_type_t  instr_type_o,
    output decode_pkg::unit_t        unit_o,
    output riscv_isa_pkg::reg_addr_t rs1_o,
    output riscv_isa_pkg::reg_addr_t rs2_o,
    output riscv_isa_pkg::reg_addr_t rd_o,
    output logic [`XLEN-1:0]         imm_o,
    output logic                     regfile_we_o,
    output logic                     use_imm_o,
    output logic                     use_pc_o,
    output logic                     change_pc_o,
    output logic                     is_jal_o,
    output logic                     is_jalr_o,
    output logic                     illegal_o,
    output logic                     link_push_o,
    output logic                     link_pop_o
);

    import riscv_isa_pkg::*;
    import decode_pkg::*;

    opcode_t          opcode;
    funct3_t          funct3;
    funct7_t          funct7;
    reg_addr_t        rs1;
    reg_addr_t        rd;
    logic [`XLEN-1:0] imm_i_type;
    logic [`XLEN-1:0] imm_s_type;
    logic [`XLEN-1:0] imm_b_type;
    logic [`XLEN-1:0] imm_u_type;
    logic [`XLEN-1:0] imm_j_type;
    logic             we;
    logic             use_imm;
    logic             use_pc;
    logic             change_pc;
    logic             link_rd;
    logic             link_rs1;

    assign opcode = opcode_t'(instr_i[6:0]);
    assign funct3 = instr_i[14:12];
    assign funct7 = instr_i[31:25];
    assign rd     = instr_i[11:7];
    assign rs1    = instr_i[19:15];

    assign rd_o  = rd;
    assign rs2_o = instr_i[24:20];
    assign rs1_o = (opcode == OP_LUI) ? REG_ZERO : rs1; // lui is x0 | imm

    assign imm_i_type = {{(`XLEN-12){instr_i[31]}}, instr_i[31:20]};
    assign imm_s_type = {{(`XLEN-12){instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_type = {{(`XLEN-13){instr_i[31]}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_type = {{(`XLEN-32){instr_i[31]}}, instr_i[31:12], 12'b0};
    assign imm_j_type = {{(`XLEN-21){instr_i[31]}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};

    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC: imm_o = imm_u_type;
            OP_JAL:           imm_o = imm_j_type;
            OP_BRANCH:        imm_o = imm_b_type;
            OP_JALR, OP_ALU_I, OP_ALU: imm_o = imm_i_type;
            default:          imm_o = imm_s_type; // store-shaped for the rest
        endcase
    end

    always_comb begin
        instr_type_o = ADD;
        unit_o       = UNIT_ALU;
        we           = 1'b0;
        use_imm      = 1'b0;
        use_pc       = 1'b0;
        change_pc    = 1'b0;
        is_jal_o     = 1'b0;
        is_jalr_o    = 1'b0;
        illegal_o    = 1'b0;

        case (opcode)
            OP_LUI: begin
                we           = 1'b1;
                use_imm      = 1'b1;
                instr_type_o = OR;
            end
            OP_AUIPC: begin
                we      = 1'b1;
                use_imm = 1'b1;
                use_pc  = 1'b1;
            end
            OP_JAL: begin
                we           = 1'b1; // rd gets pc+4
                use_imm      = 1'b1;
                use_pc       = 1'b1;
                instr_type_o = JAL;
                unit_o       = UNIT_BRANCH;
                is_jal_o     = 1'b1;
            end
            OP_JALR: begin
                we           = 1'b1;
                change_pc    = 1'b1;
                instr_type_o = JALR;
                unit_o       = UNIT_BRANCH;
                is_jalr_o    = 1'b1;
                illegal_o    = (funct3 != F3_JALR);
            end
            OP_BRANCH: begin
                change_pc = 1'b1;
                unit_o    = UNIT_BRANCH;
                case (funct3)
                    F3_BEQ:  instr_type_o = BEQ;
                    F3_BNE:  instr_type_o = BNE;
                    F3_BLT:  instr_type_o = BLT;
                    F3_BGE:  instr_type_o = BGE;
                    F3_BLTU: instr_type_o = BLTU;
                    F3_BGEU: instr_type_o = BGEU;
                    default: illegal_o = 1'b1;
                endcase
            end
            OP_ALU_I: begin
                we      = 1'b1;
                use_imm = 1'b1;
                case (funct3)
                    F3_ADD_SUB: instr_type_o = ADD;
                    F3_SLT:     instr_type_o = SLT;
                    F3_SLTU:    instr_type_o = SLTU;
                    F3_XOR:     instr_type_o = XOR;
                    F3_OR:      instr_type_o = OR;
                    F3_AND:     instr_type_o = AND;
                    F3_SLL: begin
                        instr_type_o = SLL;
                        // bit 25 belongs to the 6-bit shamt
                        illegal_o = (funct7[6:1] != F7_NORMAL[6:1]);
                    end
                    F3_SRL_SRA: begin
                        case (funct7[6:1])
                            F7_NORMAL[6:1]:  instr_type_o = SRL;
                            F7_SUB_SRA[6:1]: instr_type_o = SRA;
                            default:         illegal_o = 1'b1;
                        endcase
                    end
                endcase
            end
            OP_ALU: begin
                we = 1'b1;
                case ({funct7, funct3})
                    {F7_NORMAL, F3_ADD_SUB}:  instr_type_o = ADD;
                    {F7_SUB_SRA, F3_ADD_SUB}: instr_type_o = SUB;
                    {F7_NORMAL, F3_SLL}:      instr_type_o = SLL;
                    {F7_NORMAL, F3_SLT}:      instr_type_o = SLT;
                    {F7_NORMAL, F3_SLTU}:     instr_type_o = SLTU;
                    {F7_NORMAL, F3_XOR}:      instr_type_o = XOR;
                    {F7_NORMAL, F3_SRL_SRA}:  instr_type_o = SRL;
                    {F7_SUB_SRA, F3_SRL_SRA}: instr_type_o = SRA;
                    {F7_NORMAL, F3_OR}:       instr_type_o = OR;
                    {F7_NORMAL, F3_AND}:      instr_type_o = AND;
                    default:                  illegal_o = 1'b1;
                endcase
            end
            default: illegal_o = 1'b1;
        endcase
    end

    assign regfile_we_o = valid_i & we;
    assign use_imm_o    = valid_i & use_imm;
    assign use_pc_o     = valid_i & use_pc;
    assign change_pc_o  = valid_i & change_pc;

    // return address hints per the RISC-V calling convention
    assign link_rd  = (rd == REG_RA) | (rd == REG_T0);
    assign link_rs1 = (rs1 == REG_RA) | (rs1 == REG_T0);

    assign link_push_o = (is_jal_o | is_jalr_o) & link_rd;
    assign link_pop_o  = is_jalr_o & link_rs1 & (~link_rd | (rs1 != rd));

endmodule

`default_nettype wire

// File: hdl/jump_resolver.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_defs.svh"

module jump_resolver (
    input  logic                    valid_i,
    input  logic                    stall_i,
    input  logic [`XLEN-1:0]        pc_i,
    input  logic [`XLEN-1:0]        imm_i,
    input  logic                    is_jal_i,
    input  logic                    is_jalr_i,
    input  logic                    illegal_i,
    input  logic                    link_push_i,
    input  logic                    link_pop_i,
    input  logic [`XLEN-1:0]        ras_top_i,
    output logic                    ras_push_o,
    output logic                    ras_pop_o,
    output logic [`XLEN-1:0]        ras_push_addr_o,
    output logic                    jump_valid_o,
    output logic [`XLEN-1:0]        jump_addr_o,
    output logic                    xcpt_valid_o,
    output decode_pkg::xcpt_cause_t xcpt_cause_o,
    output logic [`XLEN-1:0]        xcpt_origin_o
);

    import decode_pkg::*;

    logic [`XLEN-1:0] jal_target;
    logic [`XLEN-1:0] seq_pc;
    logic             misaligned;
    logic             cmd_ok;

    assign jal_target = pc_i + imm_i;
    assign seq_pc     = pc_i + `XLEN'd4;
    assign misaligned = is_jal_i & (|imm_i[1:0]);

    // stack only moves for live, aligned, unstalled instructions
    assign cmd_ok          = valid_i & ~stall_i & ~misaligned;
    assign ras_push_o      = cmd_ok & link_push_i;
    assign ras_pop_o       = cmd_ok & link_pop_i;
    assign ras_push_addr_o = seq_pc;

    always_comb begin
        if (is_jal_i) begin
            jump_addr_o  = jal_target;
            jump_valid_o = valid_i & ~misaligned;
        end else if (is_jalr_i) begin
            jump_addr_o  = ras_top_i; // predicted return
            jump_valid_o = ras_pop_o;
        end else begin
            jump_addr_o  = seq_pc;
            jump_valid_o = 1'b0;
        end
    end

    always_comb begin
        xcpt_valid_o  = valid_i & (misaligned | illegal_i);
        xcpt_cause_o  = XCPT_NONE;
        xcpt_origin_o = '0;
        if (misaligned) begin
            xcpt_cause_o  = XCPT_ADDR_MISALIGNED;
            xcpt_origin_o = jal_target; // faulting target
        end else if (illegal_i) begin
            xcpt_cause_o = XCPT_ILLEGAL_INSTR;
        end
    end

endmodule

`default_nettype wire

// File: hdl/return_address_stack.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_defs.svh"

module return_address_stack (
    input  logic             clk_i,
    input  logic             arst_n_i,
    input  logic             push_i,
    input  logic             pop_i,
    input  logic [`XLEN-1:0] push_addr_i,
    output logic [`XLEN-1:0] top_o
);

    localparam int unsigned DEPTH = `RAS_DEPTH;
    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [`XLEN-1:0] entries [DEPTH];
    logic [PTR_W-1:0] ptr;      // next free slot
    logic [PTR_W-1:0] ptr_inc;
    logic [PTR_W-1:0] ptr_dec;

    assign ptr_inc = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    assign ptr_dec = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

    assign top_o = entries[ptr_dec];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ptr     <= '0;
            entries <= '{default: '0};
        end else begin
            case ({push_i, pop_i})
                2'b10: begin
                    entries[ptr] <= push_addr_i; // wraps over the oldest
                    ptr          <= ptr_inc;
                end
                2'b01: ptr <= ptr_dec;
                // swap the top in place
                2'b11: entries[ptr_dec] <= push_addr_i;
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hdl/riscv_defs.svh
`ifndef RISCV_DEFS_SVH
`define RISCV_DEFS_SVH

// data and address width
`define XLEN 64

// instruction width
`define ILEN 32

// return address stack entries
`define RAS_DEPTH 4

`endif

// File: hdl/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

    // major opcodes handled by decode
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_ALU_I  = 7'b0010011,
        OP_ALU    = 7'b0110011
    } opcode_t;

    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_JALR    = 3'b000;

    localparam funct3_t F3_BEQ     = 3'b000;
    localparam funct3_t F3_BNE     = 3'b001;
    localparam funct3_t F3_BLT     = 3'b100;
    localparam funct3_t F3_BGE     = 3'b101;
    localparam funct3_t F3_BLTU    = 3'b110;
    localparam funct3_t F3_BGEU    = 3'b111;

    // shared by reg-reg and reg-imm forms
    localparam funct3_t F3_ADD_SUB = 3'b000;
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SLT     = 3'b010;
    localparam funct3_t F3_SLTU    = 3'b011;
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_SRL_SRA = 3'b101;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;

    typedef logic [6:0] funct7_t;

    localparam funct7_t F7_NORMAL  = 7'b0000000;
    localparam funct7_t F7_SUB_SRA = 7'b0100000;

    typedef logic [4:0] reg_addr_t;

    localparam reg_addr_t REG_ZERO = 5'd0;
    localparam reg_addr_t REG_RA   = 5'd1; // link register
    localparam reg_addr_t REG_T0   = 5'd5; // alternate link

endpackage

`default_nettype wire

// File: sim.f
+incdir+hdl
hdl/riscv_isa_pkg.sv
hdl/decode_pkg.sv
hdl/instr_field_decoder.sv
hdl/jump_resolver.sv
hdl/return_address_stack.sv
hdl/decode_stage.sv
tests/tb_clk_gen.sv
tests/decode_stage_chk.sv
tests/tb_decode_stage.sv

// File: tests/decode_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_defs.svh"

module decode_stage_chk (
    input logic                    clk_i,
    input logic                    arst_n_i,
    input logic                    valid_i,
    input logic                    stall_i,
    input logic [`XLEN-1:0]        pc_i,
    input logic [`ILEN-1:0]        instr_i,
    input logic                    regfile_we_i,
    input logic                    change_pc_i,
    input logic                    jump_valid_i,
    input logic [`XLEN-1:0]        jump_addr_i,
    input logic                    xcpt_valid_i,
    input decode_pkg::xcpt_cause_t xcpt_cause_i,
    input logic [`XLEN-1:0]        xcpt_origin_i
);

    import decode_pkg::*;

    int unsigned      fail_cnt = 0;
    logic [`XLEN-1:0] shadow [`RAS_DEPTH];
    int unsigned      sp;
    logic [`XLEN-1:0] shadow_top;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic             is_jal;
    logic             is_jalr;
    logic             rd_link;
    logic             rs1_link;
    logic             live;
    logic             push;
    logic             pop;

    assign rd       = instr_i[11:7];
    assign rs1      = instr_i[19:15];
    assign is_jal   = instr_i[6:0] == 7'b1101111;
    assign is_jalr  = instr_i[6:0] == 7'b1100111;
    assign rd_link  = rd == 5'd1 || rd == 5'd5;
    assign rs1_link = rs1 == 5'd1 || rs1 == 5'd5;

    // instr bit 21 is imm bit 1 of a jal
    assign live = valid_i && !stall_i && !(is_jal && instr_i[21]);
    assign push = live && (is_jal || is_jalr) && rd_link;
    assign pop  = live && is_jalr && rs1_link && !(rd_link && rd == rs1);

    assign shadow_top = shadow[(sp + `RAS_DEPTH - 1) % `RAS_DEPTH];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sp     <= 0;
            shadow <= '{default: '0};
        end else if (push && pop) begin
            shadow[(sp + `RAS_DEPTH - 1) % `RAS_DEPTH] <= pc_i + 4;
        end else if (push) begin
            shadow[sp] <= pc_i + 4;
            sp         <= (sp + 1) % `RAS_DEPTH;
        end else if (pop) begin
            sp <= (sp + `RAS_DEPTH - 1) % `RAS_DEPTH;
        end
    end

    ret_target: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        pop |-> jump_valid_i && jump_addr_i == shadow_top)
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: return target %h, expected %h",
                   $time, $sampled(jump_addr_i), $sampled(shadow_top));
        end

    stalled_ret: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        valid_i && stall_i && is_jalr |-> !jump_valid_i)
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: redirect on a stalled jalr", $time);
        end

    idle_ctrl: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !valid_i |-> !(regfile_we_i || change_pc_i || jump_valid_i || xcpt_valid_i))
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: control output high with valid_i low", $time);
        end

    illegal_origin: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        xcpt_valid_i && xcpt_cause_i == XCPT_ILLEGAL_INSTR |-> xcpt_origin_i == '0)
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: illegal origin %h, expected 0",
                   $time, $sampled(xcpt_origin_i));
        end

    // misaligned jal never redirects
    misaligned_quiet: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        xcpt_valid_i && xcpt_cause_i == XCPT_ADDR_MISALIGNED |-> !jump_valid_i)
        else begin
            fail_cnt++;
            $error("CHECK FAILED at %0t: redirect on a misaligned jal", $time);
        end

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o; // 20 ns period
    end

    initial begin
        arst_n_o = 1'b0;
        repeat (4) @(posedge clk_o);
        #2 arst_n_o = 1'b1; // released with the stimulus offset
    end

endmodule

`default_nettype wire

// File: tests/tb_decode_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "riscv_defs.svh"

module tb_decode_stage;

    import riscv_isa_pkg::*;
    import decode_pkg::*;

    // about 450 stimulus cycles plus reset, with margin
    localparam int unsigned MAX_CYCLES = 2000;

    logic             clk;
    logic             arst_n;
    logic             valid;
    logic             stall;
    logic [`XLEN-1:0] pc;
    logic [`ILEN-1:0] instr;
    logic             valid_out;
    instr_type_t      instr_type;
    unit_t            unit;
    reg_addr_t        rs1_out;
    reg_addr_t        rs2_out;
    reg_addr_t        rd_out;
    logic [`XLEN-1:0] imm;
    logic             we;
    logic             use_imm;
    logic             use_pc;
    logic             change_pc;
    logic             jump_valid;
    logic [`XLEN-1:0] jump_addr;
    logic             xcpt_valid;
    xcpt_cause_t      xcpt_cause;
    logic [`XLEN-1:0] xcpt_origin;
    logic [31:0]      rng;
    int unsigned      cycles;

    tb_clk_gen i_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    decode_stage i_decode_stage (
        .clk_i         (clk),
        .arst_n_i      (arst_n),
        .valid_i       (valid),
        .stall_i       (stall),
        .pc_i          (pc),
        .instr_i       (instr),
        .valid_o       (valid_out),
        .instr_type_o  (instr_type),
        .unit_o        (unit),
        .rs1_o         (rs1_out),
        .rs2_o         (rs2_out),
        .rd_o          (rd_out),
        .imm_o         (imm),
        .regfile_we_o  (we),
        .use_imm_o     (use_imm),
        .use_pc_o      (use_pc),
        .change_pc_o   (change_pc),
        .jump_valid_o  (jump_valid),
        .jump_addr_o   (jump_addr),
        .xcpt_valid_o  (xcpt_valid),
        .xcpt_cause_o  (xcpt_cause),
        .xcpt_origin_o (xcpt_origin)
    );

    bind decode_stage decode_stage_chk i_decode_stage_chk (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .valid_i       (valid_i),
        .stall_i       (stall_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .regfile_we_i  (regfile_we_o),
        .change_pc_i   (change_pc_o),
        .jump_valid_i  (jump_valid_o),
        .jump_addr_i   (jump_addr_o),
        .xcpt_valid_i  (xcpt_valid_o),
        .xcpt_cause_i  (xcpt_cause_o),
        .xcpt_origin_i (xcpt_origin_o)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
                                              input logic [2:0] f3);
        return {12'h000, rs1, f3, rd, 7'b1100111};
    endfunction

    // reference kind and legality for the alu, alu-imm and branch groups
    function automatic logic ref_decode(input logic [31:0] w, output instr_type_t kind);
        logic [2:0]  f3;
        logic [6:0]  f7;
        instr_type_t alu_kind [8];
        instr_type_t br_kind [8];
        f3       = w[14:12];
        f7       = w[31:25];
        alu_kind = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
        br_kind  = '{BEQ, BNE, BEQ, BEQ, BLT, BGE, BLTU, BGEU};
        case (w[6:0])
            7'b1100011: begin
                kind = br_kind[f3];
                return f3[2:1] != 2'b01;
            end
            7'b0010011: begin
                kind = alu_kind[f3];
                if (f3 == 3'b101 && f7[5]) kind = SRA;
                if (f3 == 3'b001) return f7[6:1] == 6'd0;
                if (f3 == 3'b101) return !f7[6] && f7[4:1] == 4'd0; // 6-bit shamt
                return 1'b1;
            end
            default: begin
                kind = alu_kind[f3];
                if (f7 == 7'h20 && f3 == 3'b000) kind = SUB;
                if (f7 == 7'h20 && f3 == 3'b101) kind = SRA;
                return f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101));
            end
        endcase
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        assert (got === exp)
        else abort_run($sformatf("CHECK FAILED at %0t: %s got %h, expected %h",
                                 $time, what, got, exp));
    endtask

    // apply one word, then sample at the falling edge
    task automatic drive(input logic v, input logic s, input logic [63:0] at,
                         input logic [31:0] w);
        @(posedge clk);
        #2;
        valid = v;
        stall = s;
        pc    = at;
        instr = w;
        @(negedge clk);
    endtask

    task automatic check_idle(input logic [31:0] w);
        drive(1'b0, 1'b0, 64'h0, w);
        check_eq({we, change_pc, jump_valid, xcpt_valid}, 4'b0, "controls with valid_i low");
        check_eq({valid_out, use_pc}, 2'b0, "valid_o and use_pc_o");
    endtask

    task automatic check_illegal(input logic [31:0] w);
        drive(1'b1, 1'b0, 64'h1000, w);
        check_eq(xcpt_valid, 1'b1, "xcpt_valid_o");
        check_eq(xcpt_cause, XCPT_ILLEGAL_INSTR, "xcpt_cause_o");
        check_eq(xcpt_origin, 64'h0, "xcpt_origin_o");
    endtask

    task automatic check_group_word(input logic [31:0] w);
        instr_type_t kind;
        logic        legal;
        legal = ref_decode(w, kind);
        if (!legal) begin
            check_illegal(w);
        end else begin
            drive(1'b1, 1'b0, 64'h1000, w);
            check_eq(xcpt_valid, 1'b0, "xcpt_valid_o");
            check_eq(instr_type, kind, "instr_type_o");
            check_eq(valid_out, 1'b1, "valid_o");
            check_eq(use_pc, 1'b0, "use_pc_o");
            check_eq(rd_out, w[11:7], "rd_o");
            check_eq(rs1_out, w[19:15], "rs1_o");
            if (w[6:0] == 7'b1100011) begin
                check_eq(change_pc, 1'b1, "change_pc_o");
                check_eq(unit, UNIT_BRANCH, "unit_o");
            end else begin
                check_eq(we, 1'b1, "regfile_we_o");
                check_eq(unit, UNIT_ALU, "unit_o");
            end
            if (w[6:0] == 7'b0010011) begin
                check_eq(use_imm, 1'b1, "use_imm_o");
                check_eq(imm, {{(`XLEN-12){w[31]}}, w[31:20]}, "imm_o");
            end else begin
                check_eq(rs2_out, w[24:20], "rs2_o");
            end
        end
    endtask

    task automatic check_jal(input logic [63:0] at, input logic [20:0] off);
        logic [63:0] target;
        target = at + {{(`XLEN-21){off[20]}}, off};
        drive(1'b1, 1'b0, at, jal_word(5'd0, off));
        check_eq(jump_valid, !off[1], "jump_valid_o");
        check_eq(xcpt_valid, off[1], "xcpt_valid_o");
        if (off[1]) begin
            check_eq(xcpt_cause, XCPT_ADDR_MISALIGNED, "xcpt_cause_o");
            check_eq(xcpt_origin, target, "xcpt_origin_o");
        end else begin
            check_eq(jump_addr, target, "jump_addr_o");
        end
    endtask

    task automatic check_return(input logic stalled, input logic [63:0] exp);
        drive(1'b1, stalled, 64'h8000, jalr_word(5'd0, 5'd1, 3'b000));
        check_eq(jump_valid, !stalled, "jump_valid_o");
        if (!stalled) check_eq(jump_addr, exp, "jump_addr_o");
    endtask

    always @(negedge clk) begin
        cycles <= cycles + 1;
        if (i_decode_stage.i_decode_stage_chk.fail_cnt != 0) begin
            abort_run("an assertion in the checker failed");
        end else if (cycles >= MAX_CYCLES) begin
            abort_run($sformatf("timeout: run did not finish in %0d cycles", cycles));
        end
    end

    initial begin
        logic [31:0] w;
        rng    = 32'h0dd5f0b4;
        cycles = 0;
        valid  = 1'b0;
        stall  = 1'b0;
        pc     = '0;
        instr  = '0;
        @(posedge arst_n);
        check_idle(jal_word(5'd1, 21'h40));
        check_idle(32'h0000_0013);

        check_group_word(32'h0020_8063); // beq
        check_group_word(32'h0020_a0e3 & 32'hffff_bfff);
        check_group_word(32'h0020_a063 | 32'h0000_3000); // funct3 011
        check_group_word(32'h4020_8133); // sub
        check_group_word(32'h4030_d093); // srai
        check_illegal(32'h0000_2003); // load opcode
        check_illegal(jalr_word(5'd0, 5'd2, 3'b001));

        drive(1'b1, 1'b0, 64'h1000, 32'h1234_5097); // auipc x1
        check_eq(use_pc, 1'b1, "use_pc_o");
        check_eq(imm, 64'h1234_5000, "imm_o");

        check_jal(64'h2000, 21'h000100);
        check_jal(64'h3000, 21'h1fffe0); // backward
        check_jal(64'h2000, 21'h000102);

        // nested calls to full depth, then unwind
        for (int k = 0; k < `RAS_DEPTH; k++) begin
            drive(1'b1, 1'b0, 64'h4000 + 64'(k) * 64'h100, jal_word(5'd1, 21'h40));
        end
        for (int k = `RAS_DEPTH - 1; k >= 0; k--) begin
            check_return(1'b0, 64'h4004 + 64'(k) * 64'h100);
        end
        drive(1'b1, 1'b0, 64'h5000, jalr_word(5'd1, 5'd2, 3'b000));
        check_return(1'b0, 64'h5004);

        drive(1'b1, 1'b0, 64'h6000, jal_word(5'd1, 21'h80));
        check_return(1'b1, 64'h0);
        check_return(1'b0, 64'h6004);

        repeat (400) begin
            rng = xorshift32(rng);
            w   = rng;
            w[6:0] = (rng[1:0] == 2'd0) ? 7'b1100011 : (rng[1] ? 7'b0110011 : 7'b0010011);
            if (rng[8:7] != 2'b00) w[31:25] = {1'b0, rng[9], 5'b0};
            check_group_word(w);
        end

        check_idle(32'h0000_0000);
        @(negedge clk);
        if (i_decode_stage.i_decode_stage_chk.fail_cnt == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            abort_run("an assertion in the checker failed");
        end
    end

endmodule

`default_nettype wire
